// File: common/rob_pkg.sv
package rob_pkg;

    localparam int xlen     = 32;
    localparam int rob_size = 4;  // default rob_depth
    localparam int tag_len  = 3;  // tag 0 is reserved for "no tag"

    typedef logic [tag_len-1:0] rob_tag_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [31:0]        inst_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] npc;
        inst_t           inst;
        logic            wr_mem;         // store
        reg_idx_t        dest_reg;
        logic [xlen-1:0] dest_addr;      // store address from the cdb
        logic [xlen-1:0] value;          // result, or store data
        rob_tag_t        store_dep;      // producer of the store data
        logic [2:0]      mem_size;
        logic            value_ready;
        logic            address_ready;  // set at allocation for non-stores
    } rob_entry_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        rob_tag;
        logic [xlen-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic            valid;
        inst_t           inst;
        logic [xlen-1:0] npc;
        logic            wr_mem;
        reg_idx_t        dest_reg;
        logic [2:0]      mem_size;
        reg_idx_t        rs1;
        reg_idx_t        rs2;            // also the store data register
        logic [xlen-1:0] store_value_in;
        logic            store_value_valid;
    } dispatch_t;

    typedef struct packed {
        logic            valid;
        logic            wr_mem;
        reg_idx_t        dest_reg;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] value;
        logic [2:0]      mem_size;
        rob_tag_t        tag;
    } commit_t;

endpackage

// File: design/rob/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int rob_depth = rob_pkg::rob_size
) (
    input  logic                      clock,
    input  logic                      reset,
    input  rob_pkg::dispatch_t        dispatch,
    input  rob_pkg::rob_tag_t         store_dep,
    input  logic [rob_pkg::xlen-1:0]  alloc_value,
    input  logic                      alloc_value_valid,
    input  rob_pkg::cdb_t             cdb,
    input  rob_pkg::rob_tag_t         read_tag_rs1,
    input  rob_pkg::rob_tag_t         read_tag_rs2,
    output logic [rob_pkg::xlen-1:0]  read_value_rs1,
    output logic                      read_ready_rs1,
    output logic [rob_pkg::xlen-1:0]  read_value_rs2,
    output logic                      read_ready_rs2,
    input  logic [rob_pkg::xlen-1:0]  load_address,
    input  rob_pkg::rob_tag_t         load_tag,
    output logic                      pending_stores,
    output logic                      full,
    output rob_pkg::rob_tag_t         alloc_slot,
    output rob_pkg::rob_entry_t       head_entry,
    output rob_pkg::rob_tag_t         head,
    output logic                      head_ready,
    input  logic                      retire
);
    import rob_pkg::*;

    rob_entry_t entries [1:rob_depth];
    rob_tag_t   tail;
    logic       alloc;
    rob_entry_t new_entry;
    rob_tag_t   search_idx;
    logic       search_done;

    // tags wrap from rob_depth back to 1
    function automatic rob_tag_t next_tag(input rob_tag_t t);
        return (t == rob_tag_t'(rob_depth)) ? rob_tag_t'(1) : rob_tag_t'(t + 1'b1);
    endfunction

    function automatic rob_tag_t prev_tag(input rob_tag_t t);
        return (t == rob_tag_t'(1)) ? rob_tag_t'(rob_depth) : rob_tag_t'(t - 1'b1);
    endfunction

    function automatic logic in_range(input rob_tag_t t);
        return (t != '0) && (int'(t) <= rob_depth);
    endfunction

    assign alloc = dispatch.valid && !full;

    // tail entry, with the store data taken from the cdb if it arrives now
    always_comb begin
        new_entry               = '0;
        new_entry.valid         = 1'b1;
        new_entry.npc           = dispatch.npc;
        new_entry.inst          = dispatch.inst;
        new_entry.wr_mem        = dispatch.wr_mem;
        new_entry.dest_reg      = dispatch.dest_reg;
        new_entry.mem_size      = dispatch.mem_size;
        new_entry.address_ready = !dispatch.wr_mem;
        if (dispatch.wr_mem) begin
            new_entry.store_dep   = store_dep;
            new_entry.value       = alloc_value;
            new_entry.value_ready = alloc_value_valid;
            if (!alloc_value_valid && cdb.valid && store_dep != '0 &&
                cdb.rob_tag == store_dep) begin
                new_entry.value       = cdb.value;
                new_entry.value_ready = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i <= rob_depth; i++) begin
                entries[i].valid         <= 1'b0;
                entries[i].value_ready   <= 1'b0;
                entries[i].address_ready <= 1'b0;
            end
        end else begin
            if (cdb.valid) begin
                for (int i = 1; i <= rob_depth; i++) begin
                    if (rob_tag_t'(i) == cdb.rob_tag) begin
                        if (entries[i].wr_mem) begin
                            entries[i].dest_addr     <= cdb.value;  // store address
                            entries[i].address_ready <= 1'b1;
                        end else begin
                            entries[i].value       <= cdb.value;
                            entries[i].value_ready <= 1'b1;
                        end
                    end else if (entries[i].valid && entries[i].wr_mem &&
                                 !entries[i].value_ready &&
                                 entries[i].store_dep == cdb.rob_tag) begin
                        // waiting store picks up its data
                        entries[i].value       <= cdb.value;
                        entries[i].value_ready <= 1'b1;
                    end
                end
            end
            if (retire) begin
                entries[head].valid         <= 1'b0;
                entries[head].value_ready   <= 1'b0;
                entries[head].address_ready <= 1'b0;
            end
            if (alloc)
                entries[tail] <= new_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= rob_tag_t'(1);
            tail <= rob_tag_t'(1);
        end else begin
            if (retire)
                head <= next_tag(head);
            if (alloc)
                tail <= next_tag(tail);
        end
    end

    // operand reads for renamed registers
    always_comb begin
        read_value_rs1 = '0;
        read_ready_rs1 = 1'b0;
        read_value_rs2 = '0;
        read_ready_rs2 = 1'b0;
        if (in_range(read_tag_rs1)) begin
            read_value_rs1 = entries[read_tag_rs1].value;
            read_ready_rs1 = entries[read_tag_rs1].valid && entries[read_tag_rs1].value_ready;
        end
        if (in_range(read_tag_rs2)) begin
            read_value_rs2 = entries[read_tag_rs2].value;
            read_ready_rs2 = entries[read_tag_rs2].valid && entries[read_tag_rs2].value_ready;
        end
    end

    // walk back from the entry before the load down to the head
    always_comb begin
        pending_stores = 1'b0;
        search_idx     = prev_tag(load_tag);
        search_done    = 1'b1;
        if (in_range(load_tag))
            search_done = !entries[load_tag].valid || load_tag == head;
        for (int k = 1; k < rob_depth; k++) begin
            if (!search_done) begin
                if (entries[search_idx].valid && entries[search_idx].wr_mem &&
                    entries[search_idx].address_ready &&
                    entries[search_idx].dest_addr == load_address)
                    pending_stores = 1'b1;
                if (search_idx == head)
                    search_done = 1'b1;  // oldest entry reached
                else
                    search_idx = prev_tag(search_idx);
            end
        end
    end

    assign head_entry = entries[head];
    assign head_ready = entries[head].valid && entries[head].value_ready &&
                        entries[head].address_ready;
    assign full       = entries[head].valid && tail == head;  // every slot in use
    assign alloc_slot = tail;

endmodule

// File: design/rob/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                 clock,
    input  logic                 reset,
    input  rob_pkg::rob_entry_t  head_entry,
    input  logic                 head_ready,
    input  rob_pkg::rob_tag_t    head,
    output logic                 retire,
    output rob_pkg::commit_t     commit
);
    import rob_pkg::*;

    logic is_store;

    assign is_store = head_entry.wr_mem;

    // one head leaves per cycle, so retire follows head_ready directly
    assign retire = head_ready;

    always_ff @(posedge clock) begin
        if (reset)
            commit.valid <= 1'b0;
        else
            commit.valid <= head_ready;

        if (head_ready) begin
            commit.wr_mem   <= is_store;
            commit.mem_size <= head_entry.mem_size;
            commit.tag      <= head;
            commit.value    <= head_entry.value;  // result or store data
            if (is_store) begin
                commit.dest_reg <= reg_idx_t'(0);  // stores write no register
                commit.addr     <= head_entry.dest_addr;
            end else begin
                commit.dest_reg <= head_entry.dest_reg;
                commit.addr     <= '0;
            end
        end
    end

endmodule

// File: design/map_table.sv
`timescale 1ns/1ps

module map_table (
    input  logic               clock,
    input  logic               reset,
    input  logic               set_valid,
    input  rob_pkg::reg_idx_t  set_reg,
    input  rob_pkg::rob_tag_t  set_tag,
    input  logic               clear_valid,
    input  rob_pkg::reg_idx_t  clear_reg,
    input  rob_pkg::rob_tag_t  clear_tag,
    input  rob_pkg::reg_idx_t  rs1,
    input  rob_pkg::reg_idx_t  rs2,
    output rob_pkg::rob_tag_t  rs1_tag,
    output rob_pkg::rob_tag_t  rs2_tag
);
    import rob_pkg::*;

    rob_tag_t tags [32];  // 0 means the register file holds the value
    logic     do_set;
    logic     do_clear;

    // x0 is never renamed
    assign do_set = set_valid && set_reg != reg_idx_t'(0);

    // a newer rename of the same register must survive an older commit
    assign do_clear = clear_valid && tags[clear_reg] == clear_tag &&
                      !(do_set && set_reg == clear_reg);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < 32; r++)
                tags[r] <= '0;
        end else begin
            if (do_clear)
                tags[clear_reg] <= '0;
            if (do_set)
                tags[set_reg] <= set_tag;  // set wins on the same register
        end
    end

    assign rs1_tag = tags[rs1];
    assign rs2_tag = tags[rs2];

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      write_enable,
    input  rob_pkg::reg_idx_t         write_reg,
    input  logic [rob_pkg::xlen-1:0]  write_value,
    input  rob_pkg::reg_idx_t         rs1,
    input  rob_pkg::reg_idx_t         rs2,
    output logic [rob_pkg::xlen-1:0]  rs1_value,
    output logic [rob_pkg::xlen-1:0]  rs2_value
);
    import rob_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < 32; r++)
                regs[r] <= '0;
        end else if (write_enable && write_reg != reg_idx_t'(0)) begin
            regs[write_reg] <= write_value;
        end
    end

    // x0 reads as zero whatever is stored there
    assign rs1_value = (rs1 == reg_idx_t'(0)) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == reg_idx_t'(0)) ? '0 : regs[rs2];

endmodule

// File: design/ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
    parameter int rob_depth = rob_pkg::rob_size
) (
    input  logic                      clock,
    input  logic                      reset,
    input  rob_pkg::dispatch_t        dispatch,
    output logic                      dispatch_accept,
    input  rob_pkg::cdb_t             cdb,
    input  logic [rob_pkg::xlen-1:0]  load_address,
    input  rob_pkg::rob_tag_t         load_tag,
    output logic                      pending_stores,
    output logic [rob_pkg::xlen-1:0]  rs1_value,
    output logic                      rs1_ready,
    output logic [rob_pkg::xlen-1:0]  rs2_value,
    output logic                      rs2_ready,
    output rob_pkg::rob_tag_t         alloc_slot,
    output logic                      full,
    output rob_pkg::commit_t          commit
);
    import rob_pkg::*;

    rob_tag_t        rs1_tag, rs2_tag;
    logic [xlen-1:0] rf_rs1_value, rf_rs2_value;
    logic [xlen-1:0] rob_rs1_value, rob_rs2_value;
    logic            rob_rs1_ready, rob_rs2_ready;
    logic [xlen-1:0] alloc_value;
    logic            alloc_value_valid;
    rob_entry_t      head_entry;
    rob_tag_t        head;
    logic            head_ready;
    logic            retire;
    logic            reg_write;

    assign dispatch_accept = dispatch.valid && !full;
    assign reg_write       = retire && !head_entry.wr_mem;

    // renamed registers read from the rob, others from the register file
    assign rs1_value = (rs1_tag != '0) ? rob_rs1_value : rf_rs1_value;
    assign rs1_ready = (rs1_tag == '0) || rob_rs1_ready;
    assign rs2_value = (rs2_tag != '0) ? rob_rs2_value : rf_rs2_value;
    assign rs2_ready = (rs2_tag == '0) || rob_rs2_ready;

    // store data: own field first, then whatever rs2 lookup has
    assign alloc_value       = dispatch.store_value_valid ? dispatch.store_value_in : rs2_value;
    assign alloc_value_valid = dispatch.store_value_valid || rs2_ready;

    rob #(.rob_depth(rob_depth)) u_rob (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .store_dep(rs2_tag),
        .alloc_value(alloc_value), .alloc_value_valid(alloc_value_valid),
        .cdb(cdb),
        .read_tag_rs1(rs1_tag), .read_tag_rs2(rs2_tag),
        .read_value_rs1(rob_rs1_value), .read_ready_rs1(rob_rs1_ready),
        .read_value_rs2(rob_rs2_value), .read_ready_rs2(rob_rs2_ready),
        .load_address(load_address), .load_tag(load_tag),
        .pending_stores(pending_stores),
        .full(full), .alloc_slot(alloc_slot),
        .head_entry(head_entry), .head(head), .head_ready(head_ready),
        .retire(retire)
    );

    commit_unit u_commit (
        .clock(clock), .reset(reset),
        .head_entry(head_entry), .head_ready(head_ready), .head(head),
        .retire(retire), .commit(commit)
    );

    map_table u_map (
        .clock(clock), .reset(reset),
        .set_valid(dispatch_accept && !dispatch.wr_mem),  // stores rename nothing
        .set_reg(dispatch.dest_reg), .set_tag(alloc_slot),
        .clear_valid(reg_write), .clear_reg(head_entry.dest_reg), .clear_tag(head),
        .rs1(dispatch.rs1), .rs2(dispatch.rs2),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag)
    );

    reg_file u_rf (
        .clock(clock), .reset(reset),
        .write_enable(reg_write), .write_reg(head_entry.dest_reg),
        .write_value(head_entry.value),
        .rs1(dispatch.rs1), .rs2(dispatch.rs2),
        .rs1_value(rf_rs1_value), .rs2_value(rf_rs2_value)
    );

endmodule

// File: bench/rob_props.sv
`timescale 1ns/1ps

module rob_props #(
    parameter int rob_depth = rob_pkg::rob_size
) (
    input logic                 clock,
    input logic                 reset,
    input rob_pkg::rob_entry_t  entries [1:rob_depth],
    input logic                 full,
    input logic                 retire,
    input rob_pkg::rob_tag_t    head,
    input rob_pkg::rob_tag_t    tail
);
    logic any_free;

    always_comb begin
        any_free = 1'b0;
        for (int i = 1; i <= rob_depth; i++)
            if (!entries[i].valid) any_free = 1'b1;
    end

    full_means_no_free: assert property (@(posedge clock) disable iff (reset) full |-> !any_free)
        else $error("rob reports full while an entry is free");

    // the retired slot is released and not refilled on the same edge
    retire_frees_head: assert property (@(posedge clock) disable iff (reset)
        retire |=> !entries[$past(head)].valid)
        else $error("retired entry is still valid");

    pointers_in_range: assert property (@(posedge clock) disable iff (reset)
        head >= 1 && int'(head) <= rob_depth && tail >= 1 && int'(tail) <= rob_depth)
        else $error("head or tail outside 1 to rob_depth");

endmodule

bind rob rob_props #(.rob_depth(rob_depth)) i_rob_props (
    .clock(clock), .reset(reset), .entries(entries), .full(full), .retire(retire),
    .head(head), .tail(tail)
);

// File: bench/ooo_core_checker.sv
`timescale 1ns/1ps

module ooo_core_checker #(
    parameter int rob_depth = rob_pkg::rob_size
) (
    input  logic                      clock,
    input  logic                      reset,
    input  rob_pkg::dispatch_t        dispatch,
    input  rob_pkg::cdb_t             cdb,
    input  logic [rob_pkg::xlen-1:0]  load_address,
    input  rob_pkg::rob_tag_t         load_tag,
    input  logic                      dispatch_accept,
    input  logic                      full,
    input  rob_pkg::rob_tag_t         alloc_slot,
    input  rob_pkg::commit_t          commit,
    input  logic                      pending_stores,
    input  logic [rob_pkg::xlen-1:0]  rs1_value,
    input  logic                      rs1_ready,
    input  logic [rob_pkg::xlen-1:0]  rs2_value,
    input  logic                      rs2_ready,
    output int                        errors,
    output int                        outstanding
);
    import rob_pkg::*;

    logic            m_valid [1:rob_depth];
    logic            m_store [1:rob_depth];
    reg_idx_t        m_dest [1:rob_depth];
    logic [xlen-1:0] m_value [1:rob_depth];
    logic            m_vready [1:rob_depth];
    logic [xlen-1:0] m_addr [1:rob_depth];
    logic            m_aready [1:rob_depth];
    rob_tag_t        m_dep [1:rob_depth];
    logic [2:0]      m_size [1:rob_depth];
    rob_tag_t        m_head, m_tail;
    rob_tag_t        map [32];
    logic [xlen-1:0] rf [32];
    commit_t         expected;

    function automatic rob_tag_t step_fwd(input rob_tag_t t);
        return (int'(t) == rob_depth) ? rob_tag_t'(1) : rob_tag_t'(t + 1'b1);
    endfunction

    function automatic rob_tag_t step_back(input rob_tag_t t);
        return (t == rob_tag_t'(1)) ? rob_tag_t'(rob_depth) : rob_tag_t'(t - 1'b1);
    endfunction

    task automatic report(input string what, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] want);
        $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    always @(posedge clock) begin
        logic            ret, alloc;
        rob_tag_t        dep;
        logic [xlen-1:0] data;
        logic            data_ok;
        if (reset) begin
            for (int i = 1; i <= rob_depth; i++) m_valid[i] = 1'b0;
            for (int r = 0; r < 32; r++) begin
                map[r] = '0;
                rf[r]  = '0;
            end
            m_head = rob_tag_t'(1);
            m_tail = rob_tag_t'(1);
            outstanding = 0;
            expected = '0;
        end else begin
            ret   = m_valid[m_head] && m_vready[m_head] && m_aready[m_head];
            alloc = dispatch.valid && outstanding < rob_depth;
            expected       = '0;
            expected.valid = ret;
            if (ret) begin
                expected.wr_mem   = m_store[m_head];
                expected.dest_reg = m_store[m_head] ? reg_idx_t'(0) : m_dest[m_head];
                expected.value    = m_value[m_head];
                expected.addr     = m_store[m_head] ? m_addr[m_head] : '0;
                expected.mem_size = m_size[m_head];
                expected.tag      = m_head;
            end
            // store data source, from state before this edge
            dep     = map[dispatch.rs2];
            data    = (dispatch.rs2 == reg_idx_t'(0)) ? '0 : rf[dispatch.rs2];
            data_ok = 1'b1;
            if (dispatch.store_value_valid) begin
                data = dispatch.store_value_in;
            end else if (dep != '0) begin
                data    = m_value[dep];
                data_ok = m_valid[dep] && m_vready[dep];
                if (!data_ok && cdb.valid && cdb.rob_tag == dep) begin
                    data    = cdb.value;
                    data_ok = 1'b1;
                end
            end
            if (cdb.valid) begin
                for (int i = 1; i <= rob_depth; i++) begin
                    if (rob_tag_t'(i) == cdb.rob_tag) begin
                        if (m_store[i]) begin
                            m_addr[i]   = cdb.value;
                            m_aready[i] = 1'b1;
                        end else begin
                            m_value[i]  = cdb.value;
                            m_vready[i] = 1'b1;
                        end
                    end else if (m_valid[i] && m_store[i] && !m_vready[i] &&
                                 m_dep[i] == cdb.rob_tag) begin
                        m_value[i]  = cdb.value;
                        m_vready[i] = 1'b1;
                    end
                end
            end
            if (ret) begin
                m_valid[m_head] = 1'b0;
                if (!m_store[m_head]) begin
                    if (m_dest[m_head] != reg_idx_t'(0)) rf[m_dest[m_head]] = m_value[m_head];
                    if (map[m_dest[m_head]] == m_head) map[m_dest[m_head]] = '0;
                end
                m_head = step_fwd(m_head);
                outstanding--;
            end
            if (alloc) begin
                m_valid[m_tail]  = 1'b1;
                m_store[m_tail]  = dispatch.wr_mem;
                m_dest[m_tail]   = dispatch.dest_reg;
                m_dep[m_tail]    = dispatch.wr_mem ? dep : '0;
                m_value[m_tail]  = dispatch.wr_mem ? data : '0;
                m_vready[m_tail] = dispatch.wr_mem && data_ok;
                m_aready[m_tail] = !dispatch.wr_mem;
                m_size[m_tail]   = dispatch.mem_size;
                if (!dispatch.wr_mem && dispatch.dest_reg != reg_idx_t'(0))
                    map[dispatch.dest_reg] = m_tail;  // set wins over the clear above
                m_tail = step_fwd(m_tail);
                outstanding++;
            end
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clock) begin
        rob_tag_t t;
        logic     want_ready;
        logic     want_pending;
        if (!reset) begin
            if (commit.valid !== expected.valid)
                report("commit.valid", 32'(commit.valid), 32'(expected.valid));
            else if (expected.valid) begin
                if (commit.tag !== expected.tag)
                    report("commit.tag", 32'(commit.tag), 32'(expected.tag));
                if (commit.wr_mem !== expected.wr_mem)
                    report("commit.wr_mem", 32'(commit.wr_mem), 32'(expected.wr_mem));
                if (commit.dest_reg !== expected.dest_reg)
                    report("commit.dest_reg", 32'(commit.dest_reg), 32'(expected.dest_reg));
                if (commit.value !== expected.value)
                    report("commit.value", commit.value, expected.value);
                if (commit.addr !== expected.addr)
                    report("commit.addr", commit.addr, expected.addr);
                if (commit.mem_size !== expected.mem_size)
                    report("commit.mem_size", 32'(commit.mem_size), 32'(expected.mem_size));
            end
            if (full !== (outstanding == rob_depth))
                report("full", 32'(full), 32'(outstanding == rob_depth));
            if (dispatch_accept !== (dispatch.valid && outstanding < rob_depth))
                report("dispatch_accept", 32'(dispatch_accept),
                       32'(dispatch.valid && outstanding < rob_depth));
            if (alloc_slot !== m_tail) report("alloc_slot", 32'(alloc_slot), 32'(m_tail));
            t = map[dispatch.rs1];
            want_ready = (t == '0) || (m_valid[t] && m_vready[t]);
            if (rs1_ready !== want_ready) report("rs1_ready", 32'(rs1_ready), 32'(want_ready));
            else if (want_ready && rs1_value !== ((t == '0) ? rf[dispatch.rs1] : m_value[t]))
                report("rs1_value", rs1_value, (t == '0) ? rf[dispatch.rs1] : m_value[t]);
            t = map[dispatch.rs2];
            want_ready = (t == '0) || (m_valid[t] && m_vready[t]);
            if (rs2_ready !== want_ready) report("rs2_ready", 32'(rs2_ready), 32'(want_ready));
            else if (want_ready && rs2_value !== ((t == '0) ? rf[dispatch.rs2] : m_value[t]))
                report("rs2_value", rs2_value, (t == '0) ? rf[dispatch.rs2] : m_value[t]);
            want_pending = 1'b0;
            if (load_tag != '0 && int'(load_tag) <= rob_depth && m_valid[load_tag] &&
                load_tag != m_head) begin
                t = step_back(load_tag);
                for (int k = 1; k < rob_depth; k++) begin
                    if (m_valid[t] && m_store[t] && m_aready[t] && m_addr[t] == load_address)
                        want_pending = 1'b1;
                    if (t == m_head) break;  // oldest entry
                    t = step_back(t);
                end
            end
            if (pending_stores !== want_pending)
                report("pending_stores", 32'(pending_stores), 32'(want_pending));
        end
    end

endmodule

// File: bench/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;
    import rob_pkg::*;

    localparam int depth = rob_size;
    localparam int steps = 16;

    logic            clock;
    logic            reset;
    dispatch_t       dispatch;
    logic            dispatch_accept;
    cdb_t            cdb;
    logic [xlen-1:0] load_address;
    rob_tag_t        load_tag;
    logic            pending_stores;
    logic [xlen-1:0] rs1_value, rs2_value;
    logic            rs1_ready, rs2_ready;
    rob_tag_t        alloc_slot;
    logic            full;
    commit_t         commit;
    int              errors;
    int              outstanding;

    // one row per step: a dispatch, a cdb result and a load query
    dispatch_t       step_dispatch [steps];
    cdb_t            step_cdb [steps];
    rob_tag_t        step_load_tag [steps];
    logic [xlen-1:0] step_load_addr [steps];
    logic [31:0]     rand_state;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic put_op(input int i, input int dest, input int rs1, input int rs2,
                          input logic store);
        step_dispatch[i].valid    = 1'b1;
        step_dispatch[i].inst     = 32'h13 + i;
        step_dispatch[i].npc      = 32'h1000 + 4 * i;
        step_dispatch[i].wr_mem   = store;
        step_dispatch[i].dest_reg = reg_idx_t'(dest);
        step_dispatch[i].mem_size = store ? 3'd2 : 3'd0;
        step_dispatch[i].rs1      = reg_idx_t'(rs1);
        step_dispatch[i].rs2      = reg_idx_t'(rs2);
    endtask

    task automatic put_result(input int i, input int tag, input logic [xlen-1:0] value);
        step_cdb[i].valid   = 1'b1;
        step_cdb[i].rob_tag = rob_tag_t'(tag);
        step_cdb[i].value   = value;
    endtask

    task automatic put_load(input int i, input int tag, input logic [xlen-1:0] addr);
        step_load_tag[i]  = rob_tag_t'(tag);
        step_load_addr[i] = addr;
    endtask

    task automatic build_table();
        rand_state = 32'd36537;
        for (int i = 0; i < steps; i++) begin
            step_dispatch[i] = '0;
            step_cdb[i]      = '0;
            put_load(i, 0, 0);
        end
        put_op(0, 1, 0, 0, 1'b0);   // tag 1 -> x1
        put_op(1, 2, 0, 0, 1'b0);   // tag 2 -> x2
        put_op(2, 3, 1, 2, 1'b0);   // tag 3 -> x3
        put_result(2, 2, 32'h22);   // out of order
        put_op(3, 1, 0, 0, 1'b0);   // x1 renamed again, tag 4, fills the rob
        put_result(3, 3, 32'h33);
        put_op(4, 5, 1, 0, 1'b0);   // held back while full
        rand_state = xorshift(rand_state);
        put_result(4, 1, rand_state);
        put_op(5, 0, 0, 1, 1'b1);   // store waiting on x1, forwarded at allocation
        put_result(5, 4, 32'h44);
        put_op(6, 0, 0, 5, 1'b1);   // store waiting on x5
        put_result(6, 2, 32'h100);  // store address
        put_result(7, 1, 32'h55);
        put_load(7, 3, 32'h100);
        put_result(8, 3, 32'h200);
        put_load(8, 1, 32'h100);    // store is younger than the load
        put_op(9, 6, 2, 3, 1'b0);   // operands from the register file
        put_load(9, 3, 32'h200);
        put_result(10, 4, 32'h66);
        put_load(10, 4, 32'h200);
        put_op(11, 7, 1, 6, 1'b0);
        put_load(11, 2, 32'h200);
        rand_state = xorshift(rand_state);
        put_result(12, 1, rand_state);
        put_op(13, 0, 0, 1, 1'b1);  // store data from its own field, not from x1
        step_dispatch[13].store_value_in    = 32'h77;
        step_dispatch[13].store_value_valid = 1'b1;
        put_result(14, 2, 32'h300);
    endtask

    always #50 clock = ~clock;

    ooo_core #(.rob_depth(depth)) i_dut (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .dispatch_accept(dispatch_accept),
        .cdb(cdb), .load_address(load_address), .load_tag(load_tag),
        .pending_stores(pending_stores),
        .rs1_value(rs1_value), .rs1_ready(rs1_ready),
        .rs2_value(rs2_value), .rs2_ready(rs2_ready),
        .alloc_slot(alloc_slot), .full(full), .commit(commit)
    );

    ooo_core_checker #(.rob_depth(depth)) i_checker (
        .clock(clock), .reset(reset), .dispatch(dispatch), .cdb(cdb),
        .load_address(load_address), .load_tag(load_tag),
        .dispatch_accept(dispatch_accept), .full(full), .alloc_slot(alloc_slot),
        .commit(commit), .pending_stores(pending_stores),
        .rs1_value(rs1_value), .rs1_ready(rs1_ready),
        .rs2_value(rs2_value), .rs2_ready(rs2_ready),
        .errors(errors), .outstanding(outstanding)
    );

    // each step may stall for a few cycles under back-pressure
    initial begin
        #(steps * 20 * 100);
        $display("timeout: the run did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        dispatch     = '0;
        cdb          = '0;
        load_address = '0;
        load_tag     = '0;
        build_table();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < steps; i++) begin
            @(posedge clock);
            dispatch     <= step_dispatch[i];
            cdb          <= step_cdb[i];
            load_tag     <= step_load_tag[i];
            load_address <= step_load_addr[i];
            @(negedge clock);
            while (dispatch.valid && !dispatch_accept) begin
                @(posedge clock);
                cdb.valid <= 1'b0;  // a result goes out only once
                @(negedge clock);
            end
        end
        @(posedge clock);
        dispatch.valid <= 1'b0;
        cdb.valid      <= 1'b0;
        @(negedge clock);
        while (outstanding != 0)
            @(negedge clock);
        repeat (2) @(posedge clock);
        $display("checks failed: %0d", errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: project.f
common/rob_pkg.sv
design/rob/rob.sv
design/rob/commit_unit.sv
design/map_table.sv
design/reg_file.sv
design/ooo_core.sv
bench/rob_props.sv
bench/ooo_core_checker.sv
bench/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, pass only if the log holds the pass message
verilator --binary --timing --assert -f project.f --top-module ooo_core_tb \
    -o ooo_core_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ooo_core_sim > sim.log 2>&1
cat sim.log
grep -q "Done: no errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
